// File: a2_card_glue.f
rtl/a2glue_pkg.sv
rtl/signal_denoise.sv
rtl/bus_clock_sync.sv
rtl/card_response_arbiter.sv
rtl/audio_mixer.sv
rtl/pixel_output.sv
rtl/a2_card_glue.sv
tb/a2_card_glue_tb.sv

// File: Makefile
# Verilator build and run of the card glue testbench

TOP  := a2_card_glue_tb
SRCS := $(shell cat a2_card_glue.f)

.PHONY: run clean

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

obj_dir/V$(TOP): a2_card_glue.f $(SRCS)
	verilator --binary -j 0 --top-module $(TOP) -f a2_card_glue.f

clean:
	rm -rf obj_dir

// File: tb/a2_card_glue_tb.sv
// Apple II card glue testbench
`timescale 1ns/1ns
`default_nettype none

module a2_card_glue_tb
    import a2glue_pkg::*;
();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int CLK_EDGES    = 40;  // Real edges per bus clock
    localparam int EDGE_MAX     = 40;  // Glitch, hold and width per edge at most
    localparam int DATA_CYCLES  = 2000;
    localparam int WATCHDOG_NS  =
        (RESET_CYCLES + 40 + 2 * CLK_EDGES * EDGE_MAX + DATA_CYCLES) * CLK_PERIOD * 2;
    localparam bus_drive_t DRIVE_RESET = {1'b0, {BUS_DATA_W{1'b0}}, 1'b1};

    logic clk_logic_w;
    logic rst_i;
    logic a2_phi1_i;
    logic a2_7m_i;
    logic a2_reset_n_i;
    logic speaker_en_i;
    logic scanline_en_i;
    logic [BUS_DATA_W-1:0] bus_data_i;
    logic [SCREEN_COORD_W-1:0] screen_y_i;
    card_resp_array_t cards_i;
    audio_src_t audio_i;
    rgb_t rgb_i;
    bus_timing_t timing_o;
    logic sys_reset_o;
    bus_drive_t drive_o;
    audio_mix_t mix_o;
    rgb_t rgb_o;

    logic [31:0] lfsr_q = 32'h129e;
    bus_drive_t exp_drive_q;
    audio_mix_t exp_mix_q;
    rgb_t exp_pixel_q;
    logic check_en_q = 1'b0;
    logic phi1_seen_q = 1'b0;
    int phi1_age_q = 0;
    int err_drive = 0;
    int err_mix = 0;
    int err_pixel = 0;
    int err_phase = 0;
    int err_timing = 0;
    int err_other = 0;
    int rise_cnt[2] = '{0, 0};  // Index 1 is phi1, index 0 is 7M
    int fall_cnt[2] = '{0, 0};
    int edge_cnt[2] = '{0, 0};  // 14M and 2M strobes
    int exp_rise[2] = '{0, 0};
    int exp_fall[2] = '{0, 0};

    a2_card_glue dut (.*);

    initial begin
        clk_logic_w = 1'b0;
        forever #(CLK_PERIOD / 2) clk_logic_w = ~clk_logic_w;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic lfsr_bit();
        logic out_bit;
        out_bit = lfsr_q[0];
        lfsr_q  = lfsr_q >> 1;
        if (out_bit) lfsr_q = lfsr_q ^ 32'h8020_0003;
        return out_bit;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    function automatic logic [AUDIO_SRC_W-1:0] rand_audio();
        logic [1:0] kind;
        kind = 2'(rand_bits(2));
        if (kind == 2'd0) return {1'b0, {(AUDIO_SRC_W-1){1'b1}}};  // Most positive
        if (kind == 2'd1) return {1'b1, {(AUDIO_SRC_W-1){1'b0}}};  // Most negative
        return AUDIO_SRC_W'(rand_bits(AUDIO_SRC_W));
    endfunction

    function automatic bus_drive_t ref_drive(input card_resp_array_t c,
                                             input logic [BUS_DATA_W-1:0] bus);
        bus_drive_t d;
        logic taken;
        d = {1'b0, bus, 1'b1};
        taken = 1'b0;
        for (int i = 0; i < NUM_CARDS; i++) begin
            if (c[i].rd_en && !taken) begin
                d.data_out = c[i].data;  // Lowest index reading card
                taken = 1'b1;
            end
            d.data_out_en = d.data_out_en | c[i].rd_en;
            d.irq_n = d.irq_n & c[i].irq_n;
        end
        return d;
    endfunction

    function automatic audio_mix_t ref_mix(input audio_src_t a, input logic spk_en);
        audio_mix_t m;
        int common;
        common  = int'($signed(a.ssp)) + (spk_en ? int'($signed(a.speaker)) : 0);
        m.left  = AUDIO_MIX_W'(common + int'($signed(a.mb_l)));
        m.right = AUDIO_MIX_W'(common + int'($signed(a.mb_r)));
        return m;
    endfunction

    function automatic rgb_t ref_pixel(input rgb_t p, input logic en,
                                       input logic [SCREEN_COORD_W-1:0] y);
        rgb_t q;
        q = p;
        if (en && y[0]) begin
            q.r = p.r / PIXEL_W'(2);
            q.g = p.g / PIXEL_W'(2);
            q.b = p.b / PIXEL_W'(2);
        end
        return q;
    endfunction

    // Settled bus timing with no strobe pending
    function automatic bus_timing_t ref_timing_idle(input logic phi1, input logic clk_7m);
        bus_timing_t t;
        t = '0;
        t.phi1   = phi1;
        t.phi0   = ~phi1;
        t.clk_7m = clk_7m;
        return t;
    endfunction

    task automatic check_drive(input bus_drive_t exp_v, input bus_drive_t act_v);
        if (act_v !== exp_v) begin
            err_drive++;
            $display("** Error drive_o: expected %h, got %h at %0t", exp_v, act_v, $time);
        end
    endtask

    task automatic check_mix(input audio_mix_t exp_v, input audio_mix_t act_v);
        if (act_v !== exp_v) begin
            err_mix++;
            $display("** Error mix_o: expected %h, got %h at %0t", exp_v, act_v, $time);
        end
    endtask

    task automatic check_pixel(input rgb_t exp_v, input rgb_t act_v);
        if (act_v !== exp_v) begin
            err_pixel++;
            $display("** Error rgb_o: expected %h, got %h at %0t", exp_v, act_v, $time);
        end
    endtask

    task automatic check_timing(input bus_timing_t exp_v, input bus_timing_t act_v);
        if (act_v !== exp_v) begin
            err_timing++;
            $display("** Error timing_o: expected %h, got %h at %0t", exp_v, act_v, $time);
        end
    endtask

    task automatic check_count(input string name, input int exp_v, input int act_v);
        if (act_v != exp_v) begin
            err_timing++;
            $display("** Error %s: expected %h, got %h", name, exp_v, act_v);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk_logic_w);
    endtask

    task automatic drive_clock(input logic use_phi1, input logic v);
        if (use_phi1) a2_phi1_i = v;
        else a2_7m_i = v;
    endtask

    // Real edges with random widths, some preceded by a short glitch
    task automatic exercise_clock(input logic use_phi1);
        logic level;
        level = 1'b0;
        for (int e = 0; e < CLK_EDGES; e++) begin
            if (rand_bits(1) != 0) begin
                drive_clock(use_phi1, ~level);
                wait_cycles(1 + int'(rand_bits(1)));
                drive_clock(use_phi1, level);
                wait_cycles(8 + int'(rand_bits(3)));
            end
            level = ~level;
            drive_clock(use_phi1, level);
            if (level) exp_rise[use_phi1]++;
            else exp_fall[use_phi1]++;
            wait_cycles(8 + int'(rand_bits(4)));
            check_timing(ref_timing_idle(a2_phi1_i, a2_7m_i), timing_o);
        end
    endtask

    task automatic drive_random_inputs();
        for (int i = 0; i < NUM_CARDS; i++) begin
            cards_i[i].rd_en = 1'(rand_bits(1));
            cards_i[i].data  = BUS_DATA_W'(rand_bits(BUS_DATA_W));
            cards_i[i].irq_n = (rand_bits(3) != 0);  // Mostly idle
        end
        bus_data_i    = BUS_DATA_W'(rand_bits(BUS_DATA_W));
        audio_i.ssp   = rand_audio();
        audio_i.mb_l  = rand_audio();
        audio_i.mb_r  = rand_audio();
        audio_i.speaker = rand_audio();
        speaker_en_i  = 1'(rand_bits(1));
        scanline_en_i = 1'(rand_bits(1));
        screen_y_i    = SCREEN_COORD_W'(rand_bits(SCREEN_COORD_W));
        rgb_i         = 24'(rand_bits(24));
    endtask

    // Expected results from the inputs seen at the rising edge
    always @(posedge clk_logic_w) begin
        if (rst_i) begin
            exp_drive_q <= DRIVE_RESET;
            exp_mix_q   <= '0;
            exp_pixel_q <= '0;
        end else begin
            exp_drive_q <= ref_drive(cards_i, bus_data_i);
            exp_mix_q   <= ref_mix(audio_i, speaker_en_i);
            exp_pixel_q <= ref_pixel(rgb_i, scanline_en_i, screen_y_i);
        end
        check_en_q <= 1'b1;
    end

    always @(negedge clk_logic_w) begin
        if (check_en_q) begin
            check_drive(exp_drive_q, drive_o);
            check_mix(exp_mix_q, mix_o);
            check_pixel(exp_pixel_q, rgb_o);
        end
    end

    // Cycles since the phi1 input last changed, seen at the rising edge
    always @(posedge clk_logic_w) begin
        if (a2_phi1_i !== phi1_seen_q) phi1_age_q <= 0;
        else if (phi1_age_q < 8) phi1_age_q <= phi1_age_q + 1;
        phi1_seen_q <= a2_phi1_i;
    end

    // Strobe counting, and phi0 against the settled phi1 input
    always @(negedge clk_logic_w) begin
        if (!rst_i) begin
            if (phi1_age_q >= 5 && timing_o.phi0 !== ~phi1_seen_q) begin
                err_phase++;
                $display("** Error timing_o.phi0: expected %h, got %h at %0t",
                         ~phi1_seen_q, timing_o.phi0, $time);
            end
            if (timing_o.phi1_rise) rise_cnt[1]++;
            if (timing_o.phi1_fall) fall_cnt[1]++;
            if (timing_o.clk_2m_edge) edge_cnt[1]++;
            if (timing_o.clk_7m_rise) rise_cnt[0]++;
            if (timing_o.clk_7m_fall) fall_cnt[0]++;
            if (timing_o.clk_14m_edge) edge_cnt[0]++;
        end
    end

    initial begin
        int wait_n;
        int total;
        rst_i = 1'b1;
        a2_phi1_i = 1'b0;
        a2_7m_i = 1'b0;
        a2_reset_n_i = 1'b0;
        // Busy inputs, only the reset keeps the outputs idle
        for (int i = 0; i < NUM_CARDS; i++) begin
            cards_i[i].rd_en = 1'b1;
            cards_i[i].data  = '1;
            cards_i[i].irq_n = 1'b0;
        end
        bus_data_i = '1;
        speaker_en_i = 1'b1;
        audio_i = '1;
        scanline_en_i = 1'b0;
        screen_y_i = '0;
        rgb_i = '1;

        wait_cycles(RESET_CYCLES);
        check_timing(ref_timing_idle(1'b0, 1'b0), timing_o);
        if (sys_reset_o !== 1'b1) begin
            err_other++;
            $display("sys_reset_o is low while rst_i is held");
        end
        rst_i = 1'b0;
        wait_cycles(4);
        if (sys_reset_o !== 1'b1) begin
            err_other++;
            $display("sys_reset_o released while a2_reset_n_i is still low");
        end
        a2_reset_n_i = 1'b1;
        wait_n = 0;
        while (sys_reset_o !== 1'b0 && wait_n < 8) begin
            wait_cycles(1);
            wait_n++;
        end
        if (sys_reset_o !== 1'b0) begin
            err_other++;
            $display("sys_reset_o never released after a2_reset_n_i went high");
        end

        exercise_clock(1'b1);
        exercise_clock(1'b0);
        check_count("phi1 rise strobes", exp_rise[1], rise_cnt[1]);
        check_count("phi1 fall strobes", exp_fall[1], fall_cnt[1]);
        check_count("2M strobes", exp_rise[1] + exp_fall[1], edge_cnt[1]);
        check_count("7M rise strobes", exp_rise[0], rise_cnt[0]);
        check_count("7M fall strobes", exp_fall[0], fall_cnt[0]);
        check_count("14M strobes", exp_rise[0] + exp_fall[0], edge_cnt[0]);

        repeat (DATA_CYCLES) begin
            drive_random_inputs();
            wait_cycles(1);
        end
        wait_cycles(2);  // Last results reach the checker

        total = err_drive + err_mix + err_pixel + err_phase + err_timing + err_other;
        $display("Errors: drive %0d, mix %0d, pixel %0d, phase %0d, timing %0d, other %0d",
                 err_drive, err_mix, err_pixel, err_phase, err_timing, err_other);
        if (total == 0) $display("ALL CHECKS PASSED");
        else $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/a2_card_glue.sv
// Apple II card glue top level
`timescale 1ns/1ns
`default_nettype none

module a2_card_glue
    import a2glue_pkg::*;
(
    input  wire logic                      clk_logic_w,
    input  wire logic                      rst_i,

    // Apple bus clocks and reset
    input  wire logic                      a2_phi1_i,
    input  wire logic                      a2_7m_i,
    input  wire logic                      a2_reset_n_i,

    // Card responses and bus data
    input  wire card_resp_array_t          cards_i,
    input  wire logic [BUS_DATA_W-1:0]     bus_data_i,

    // Audio
    input  wire logic                      speaker_en_i,
    input  wire audio_src_t                audio_i,

    // Video
    input  wire logic                      scanline_en_i,
    input  wire logic [SCREEN_COORD_W-1:0] screen_y_i,
    input  wire rgb_t                      rgb_i,

    output bus_timing_t                    timing_o,
    output logic                           sys_reset_o,
    output bus_drive_t                     drive_o,
    output audio_mix_t                     mix_o,
    output rgb_t                           rgb_o
);

    bus_clock_sync bus_clock_sync_inst (
        .clk_logic_w (clk_logic_w),
        .rst_i       (rst_i),
        .a2_phi1_i   (a2_phi1_i),
        .a2_7m_i     (a2_7m_i),
        .a2_reset_n_i(a2_reset_n_i),
        .timing_o    (timing_o),
        .sys_reset_o (sys_reset_o)
    );

    card_response_arbiter card_response_arbiter_inst (
        .clk_logic_w(clk_logic_w),
        .rst_i      (rst_i),
        .cards_i    (cards_i),
        .bus_data_i (bus_data_i),
        .drive_o    (drive_o)
    );

    audio_mixer audio_mixer_inst (
        .clk_logic_w (clk_logic_w),
        .rst_i       (rst_i),
        .speaker_en_i(speaker_en_i),
        .audio_i     (audio_i),
        .mix_o       (mix_o)
    );

    pixel_output pixel_output_inst (
        .clk_logic_w  (clk_logic_w),
        .rst_i        (rst_i),
        .scanline_en_i(scanline_en_i),
        .screen_y_i   (screen_y_i),
        .rgb_i        (rgb_i),
        .rgb_o        (rgb_o)
    );

endmodule

`default_nettype wire

// File: rtl/pixel_output.sv
// Pixel output stage with scanlines
`timescale 1ns/1ns
`default_nettype none

module pixel_output
    import a2glue_pkg::*;
(
    input  wire logic                      clk_logic_w,
    input  wire logic                      rst_i,
    input  wire logic                      scanline_en_i,
    input  wire logic [SCREEN_COORD_W-1:0] screen_y_i,
    input  wire rgb_t                      rgb_i,
    output rgb_t                           rgb_o
);

    logic dim_w;

    // Darken every odd line
    assign dim_w = scanline_en_i & screen_y_i[0];

    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            rgb_o <= '0;
        end else if (dim_w) begin
            rgb_o.r <= rgb_i.r >> 1;  // Half brightness
            rgb_o.g <= rgb_i.g >> 1;
            rgb_o.b <= rgb_i.b >> 1;
        end else begin
            rgb_o <= rgb_i;
        end
    end

endmodule

`default_nettype wire

// File: rtl/audio_mixer.sv
// Card audio mixer
`timescale 1ns/1ns
`default_nettype none

module audio_mixer
    import a2glue_pkg::*;
(
    input  wire logic       clk_logic_w,
    input  wire logic       rst_i,
    input  wire logic       speaker_en_i,
    input  wire audio_src_t audio_i,
    output audio_mix_t      mix_o
);

    logic signed [AUDIO_MIX_W-1:0] ssp_w;
    logic signed [AUDIO_MIX_W-1:0] mb_l_w;
    logic signed [AUDIO_MIX_W-1:0] mb_r_w;
    logic signed [AUDIO_MIX_W-1:0] speaker_w;

    // Sign extension to the mix width
    assign ssp_w     = AUDIO_MIX_W'($signed(audio_i.ssp));
    assign mb_l_w    = AUDIO_MIX_W'($signed(audio_i.mb_l));
    assign mb_r_w    = AUDIO_MIX_W'($signed(audio_i.mb_r));
    assign speaker_w = speaker_en_i ? AUDIO_MIX_W'($signed(audio_i.speaker)) : '0;  // Muted

    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            mix_o.left  <= '0;
            mix_o.right <= '0;
        end else begin
            mix_o.left  <= ssp_w + mb_l_w + speaker_w;
            mix_o.right <= ssp_w + mb_r_w + speaker_w;
        end
    end

endmodule

`default_nettype wire

// File: rtl/card_response_arbiter.sv
// Card read data and interrupt arbiter
`timescale 1ns/1ns
`default_nettype none

module card_response_arbiter
    import a2glue_pkg::*;
(
    input  wire logic                  clk_logic_w,
    input  wire logic                  rst_i,
    input  wire card_resp_array_t      cards_i,
    input  wire logic [BUS_DATA_W-1:0] bus_data_i,
    output bus_drive_t                 drive_o
);

    bus_drive_t next_w;

    always_comb begin
        next_w.data_out_en = 1'b0;
        next_w.irq_n       = 1'b1;
        for (int i = 0; i < NUM_CARDS; i++) begin
            next_w.data_out_en = next_w.data_out_en | cards_i[i].rd_en;
            next_w.irq_n       = next_w.irq_n & cards_i[i].irq_n;  // Wired-AND of open drains
        end

        // Fixed priority, serial card first
        if (cards_i[CARD_SSC].rd_en) begin
            next_w.data_out = cards_i[CARD_SSC].data;
        end else if (cards_i[CARD_SSP].rd_en) begin
            next_w.data_out = cards_i[CARD_SSP].data;
        end else if (cards_i[CARD_MB].rd_en) begin
            next_w.data_out = cards_i[CARD_MB].data;
        end else if (cards_i[CARD_DISK].rd_en) begin
            next_w.data_out = cards_i[CARD_DISK].data;
        end else begin
            next_w.data_out = bus_data_i;  // Echo the bus when nobody answers
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            drive_o.data_out_en <= 1'b0;
            drive_o.data_out    <= '0;
            drive_o.irq_n       <= 1'b1;
        end else begin
            drive_o <= next_w;
        end
    end

endmodule

`default_nettype wire

// File: rtl/bus_clock_sync.sv
// Apple bus clock and reset input stage
`timescale 1ns/1ns
`default_nettype none

module bus_clock_sync
    import a2glue_pkg::*;
(
    input  wire logic  clk_logic_w,
    input  wire logic  rst_i,
    input  wire logic  a2_phi1_i,
    input  wire logic  a2_7m_i,
    input  wire logic  a2_reset_n_i,
    output bus_timing_t timing_o,
    output logic        sys_reset_o
);

    logic [1:0] a2_reset_n_q;

    signal_denoise phi1_denoise (
        .clk_logic_w(clk_logic_w),
        .rst_i      (rst_i),
        .sig_i      (a2_phi1_i),
        .level_o    (timing_o.phi1),
        .rise_o     (timing_o.phi1_rise),
        .fall_o     (timing_o.phi1_fall)
    );

    signal_denoise clk_7m_denoise (
        .clk_logic_w(clk_logic_w),
        .rst_i      (rst_i),
        .sig_i      (a2_7m_i),
        .level_o    (timing_o.clk_7m),
        .rise_o     (timing_o.clk_7m_rise),
        .fall_o     (timing_o.clk_7m_fall)
    );

    assign timing_o.phi0         = ~timing_o.phi1;
    assign timing_o.clk_2m_edge  = timing_o.phi1_rise | timing_o.phi1_fall;  // Both phi1 edges
    assign timing_o.clk_14m_edge = timing_o.clk_7m_rise | timing_o.clk_7m_fall;

    // Apple reset is asynchronous to the logic clock
    always_ff @(posedge clk_logic_w) begin
        if (rst_i) a2_reset_n_q <= '0;
        else       a2_reset_n_q <= {a2_reset_n_q[0], a2_reset_n_i};
    end

    assign sys_reset_o = rst_i | ~a2_reset_n_q[1];

endmodule

`default_nettype wire

// File: rtl/signal_denoise.sv
// Bus clock synchronizer and glitch filter
`timescale 1ns/1ns
`default_nettype none

module signal_denoise (
    input  wire logic clk_logic_w,
    input  wire logic rst_i,
    input  wire logic sig_i,
    output logic      level_o,
    output logic      rise_o,
    output logic      fall_o
);

    logic [1:0] sync_q;   // Two flop synchronizer
    logic [1:0] hist_q;   // Older samples
    logic [2:0] window_w; // Three sample history, newest in bit 0
    logic       agree_w;

    assign window_w = {hist_q, sync_q[1]};

    // Accept only when all three samples agree on a new level
    assign agree_w = (window_w == 3'b111 || window_w == 3'b000) && (window_w[0] != level_o);

    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            sync_q  <= '0;
            hist_q  <= '0;
            level_o <= 1'b0;
            rise_o  <= 1'b0;
            fall_o  <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], sig_i};
            hist_q <= window_w[1:0];
            rise_o <= agree_w & window_w[0];
            fall_o <= agree_w & ~window_w[0];
            if (agree_w) begin
                level_o <= window_w[0];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/a2glue_pkg.sv
// Apple II card glue definitions
`default_nettype none

package a2glue_pkg;

    localparam int NUM_CARDS = 4;

    // Card slots in the response array, lower index wins the bus
    localparam int CARD_SSC  = 0;  // Serial card
    localparam int CARD_SSP  = 1;  // Sprite card
    localparam int CARD_MB   = 2;  // Sound card
    localparam int CARD_DISK = 3;  // Disk card

    localparam int BUS_DATA_W     = 8;
    localparam int AUDIO_SRC_W    = 14;
    localparam int AUDIO_MIX_W    = 16;
    localparam int PIXEL_W        = 8;
    localparam int SCREEN_COORD_W = 10;

    typedef struct packed {
        logic                  rd_en;
        logic [BUS_DATA_W-1:0] data;
        logic                  irq_n;  // Active low
    } card_resp_t;

    typedef card_resp_t [NUM_CARDS-1:0] card_resp_array_t;

    typedef struct packed {
        logic                  data_out_en;
        logic [BUS_DATA_W-1:0] data_out;
        logic                  irq_n;
    } bus_drive_t;

    // Bus clock phases and edge strobes in the logic clock domain
    typedef struct packed {
        logic phi0;
        logic phi1;
        logic phi1_rise;
        logic phi1_fall;
        logic clk_2m_edge;
        logic clk_7m;
        logic clk_7m_rise;
        logic clk_7m_fall;
        logic clk_14m_edge;
    } bus_timing_t;

    typedef struct packed {
        logic signed [AUDIO_SRC_W-1:0] ssp;
        logic signed [AUDIO_SRC_W-1:0] mb_l;
        logic signed [AUDIO_SRC_W-1:0] mb_r;
        logic signed [AUDIO_SRC_W-1:0] speaker;
    } audio_src_t;

    typedef struct packed {
        logic signed [AUDIO_MIX_W-1:0] left;
        logic signed [AUDIO_MIX_W-1:0] right;
    } audio_mix_t;

    typedef struct packed {
        logic [PIXEL_W-1:0] r;
        logic [PIXEL_W-1:0] g;
        logic [PIXEL_W-1:0] b;
    } rgb_t;

endpackage

`default_nettype wire
